// ==== source/lsu_settings.svh ====
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Cache geometry, 2 ways of one-word lines
`define LSU_NUM_SETS 4

// Set index taken from word address bits 3:2
`define LSU_SET_BITS 2

// Remaining upper address bits 31:4
`define LSU_TAG_BITS 28

// Initial credits, same as the memory request queue depth
`define LSU_MEM_CREDITS 4

`endif

// ==== source/lsu_pkg.sv ====
package lsu_pkg;

  // Memory opcode out of decode, forced to OP_ILLEGAL by execute on misalignment
  typedef enum logic [2:0] {
    OP_LB      = 3'd0,
    OP_LH      = 3'd1,
    OP_LW      = 3'd2,
    OP_LBU     = 3'd3,
    OP_LHU     = 3'd4,
    OP_SW      = 3'd5,
    OP_ILLEGAL = 3'd6
  } mem_op_e;

  // Cache sequencer states
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0, // Waiting for an instruction from execute
    ST_STORE_REQ = 3'd1, // Write-through request, needs a credit
    ST_MISS_REQ  = 3'd2, // Refill read request, needs a credit
    ST_MISS_WAIT = 3'd3, // Waiting for read data
    ST_DONE      = 3'd4  // One-cycle result handoff
  } cache_state_e;

endpackage

// ==== source/lsu_decode.sv ====
module lsu_decode (
  input  logic              is_store,
  input  logic [2:0]        funct3,
  output lsu_pkg::mem_op_e  op,
  output logic [1:0]        size_log2
);

  always_comb begin
    op        = lsu_pkg::OP_ILLEGAL; // Reserved codes fall through here
    size_log2 = 2'd0;
    if (is_store) begin
      // Only full-word stores are supported
      if (funct3 == 3'b010) begin
        op        = lsu_pkg::OP_SW;
        size_log2 = 2'd2;
      end
    end else begin
      case (funct3)
        3'b000: begin
          op        = lsu_pkg::OP_LB;
          size_log2 = 2'd0;
        end
        3'b001: begin
          op        = lsu_pkg::OP_LH;
          size_log2 = 2'd1;
        end
        3'b010: begin
          op        = lsu_pkg::OP_LW;
          size_log2 = 2'd2;
        end
        3'b100: begin
          op        = lsu_pkg::OP_LBU;
          size_log2 = 2'd0;
        end
        3'b101: begin
          op        = lsu_pkg::OP_LHU;
          size_log2 = 2'd1;
        end
        default: begin
          op        = lsu_pkg::OP_ILLEGAL; // 011, 110, 111
          size_log2 = 2'd0;
        end
      endcase
    end
  end

endmodule

// ==== source/lsu_execute.sv ====
module lsu_execute (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  lsu_pkg::mem_op_e  op,
  input  logic [1:0]        size_log2,
  input  logic [31:0]       base,
  input  logic [11:0]       offset,
  input  logic [31:0]       store_data,
  input  logic              cache_take,
  output logic              ex_valid,
  output lsu_pkg::mem_op_e  ex_op,
  output logic [31:0]       ex_addr,
  output logic [31:0]       ex_wdata
);

  logic [31:0]      addr;
  logic             misaligned;
  lsu_pkg::mem_op_e op_chk;

  assign addr = base + {{20{offset[11]}}, offset}; // Sign-extended I/S immediate

  // Halfwords need bit 0 clear, words need bits 1:0 clear
  always_comb begin
    case (size_log2)
      2'd1:    misaligned = addr[0];
      2'd2:    misaligned = |addr[1:0];
      default: misaligned = 1'b0;
    endcase
  end

  assign op_chk = misaligned ? lsu_pkg::OP_ILLEGAL : op;

  // Empty slot, or slot drains into the cache this cycle
  assign in_ready = !ex_valid || cache_take;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      ex_valid <= 1'b1;
    end else if (cache_take) begin
      ex_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      ex_op    <= op_chk;
      ex_addr  <= addr;
      ex_wdata <= store_data;
    end
  end

endmodule

// ==== source/two_way_cache.sv ====
`include "lsu_settings.svh"

module two_way_cache (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              ex_valid,
  input  lsu_pkg::mem_op_e  ex_op,
  input  logic [31:0]       ex_addr,
  input  logic [31:0]       ex_wdata,
  output logic              cache_take,
  output logic              done,
  output lsu_pkg::mem_op_e  done_op,
  output logic [31:0]       done_word,
  output logic [1:0]        done_byte_sel,
  output logic              done_hit,
  output logic              mem_req_valid,
  output logic              mem_req_write,
  output logic [31:0]       mem_req_addr,
  output logic [31:0]       mem_req_wdata,
  input  logic              mem_credit,
  input  logic              mem_rvalid,
  input  logic [31:0]       mem_rdata
);

  localparam int CW = $clog2(`LSU_MEM_CREDITS + 1); // Counts 0..LSU_MEM_CREDITS

  logic [`LSU_NUM_SETS-1:0][1:0] valid;
  logic [`LSU_NUM_SETS-1:0]      lru;         // Names the way to replace next
  logic [`LSU_TAG_BITS-1:0]      tag_mem  [`LSU_NUM_SETS][2];
  logic [31:0]                   data_mem [`LSU_NUM_SETS][2];
  logic [CW-1:0]                 credits;
  lsu_pkg::cache_state_e         state;

  lsu_pkg::mem_op_e         req_op;          // Instruction held by the cache
  logic [31:0]              req_addr;
  logic [31:0]              req_wdata;
  logic [31:0]              req_word;
  logic                     req_hit;
  logic                     req_way;         // Matching way at lookup
  logic [`LSU_SET_BITS-1:0] lk_set;
  logic [`LSU_TAG_BITS-1:0] lk_tag;
  logic [`LSU_SET_BITS-1:0] req_set;
  logic [`LSU_TAG_BITS-1:0] req_tag;
  logic                     hit0;
  logic                     hit1;
  logic                     wr_way;

  // Lookup runs on the execute address while idle
  assign lk_set = ex_addr[`LSU_SET_BITS+1:2];
  assign lk_tag = ex_addr[31:`LSU_SET_BITS+2];
  assign hit0   = valid[lk_set][0] && (tag_mem[lk_set][0] == lk_tag);
  assign hit1   = valid[lk_set][1] && (tag_mem[lk_set][1] == lk_tag);

  assign req_set = req_addr[`LSU_SET_BITS+1:2];
  assign req_tag = req_addr[31:`LSU_SET_BITS+2];
  assign wr_way  = req_hit ? req_way : lru[req_set]; // Store target, hit way or victim

  assign cache_take    = (state == lsu_pkg::ST_IDLE) && ex_valid;
  assign mem_req_valid = ((state == lsu_pkg::ST_STORE_REQ) ||
                          (state == lsu_pkg::ST_MISS_REQ)) && (credits != '0);
  assign mem_req_write = (state == lsu_pkg::ST_STORE_REQ);
  assign mem_req_addr  = {req_addr[31:2], 2'b00};   // Word aligned
  assign mem_req_wdata = req_wdata;

  assign done          = (state == lsu_pkg::ST_DONE);
  assign done_op       = req_op;
  assign done_word     = req_word;
  assign done_byte_sel = req_addr[1:0];
  assign done_hit      = req_hit;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= lsu_pkg::ST_IDLE;
      valid   <= '0;
      lru     <= '0;
      credits <= CW'(`LSU_MEM_CREDITS);
    end else begin
      credits <= credits - CW'(mem_req_valid) + CW'(mem_credit); // Spend and return
      case (state)
        lsu_pkg::ST_IDLE: if (cache_take) begin
          if (ex_op == lsu_pkg::OP_SW) begin
            state <= lsu_pkg::ST_STORE_REQ;
          end else if (ex_op == lsu_pkg::OP_ILLEGAL) begin
            state <= lsu_pkg::ST_DONE;     // No cache or memory access
          end else if (hit0 || hit1) begin
            lru[lk_set] <= ~hit1;          // Point away from the hit way
            state       <= lsu_pkg::ST_DONE;
          end else begin
            state <= lsu_pkg::ST_MISS_REQ;
          end
        end
        lsu_pkg::ST_STORE_REQ: if (mem_req_valid) begin
          valid[req_set][wr_way] <= 1'b1;  // Write-allocate
          lru[req_set]           <= ~wr_way;
          state                  <= lsu_pkg::ST_DONE;
        end
        lsu_pkg::ST_MISS_REQ: if (mem_req_valid) state <= lsu_pkg::ST_MISS_WAIT;
        lsu_pkg::ST_MISS_WAIT: if (mem_rvalid) begin
          valid[req_set][lru[req_set]] <= 1'b1;
          lru[req_set]                 <= ~lru[req_set];
          state                        <= lsu_pkg::ST_DONE;
        end
        default: state <= lsu_pkg::ST_IDLE; // ST_DONE lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cache_take) begin
      req_op    <= ex_op;
      req_addr  <= ex_addr;
      req_wdata <= ex_wdata;
      req_hit   <= (hit0 || hit1) && (ex_op != lsu_pkg::OP_ILLEGAL);
      req_way   <= hit1;
      req_word  <= hit1 ? data_mem[lk_set][1] : data_mem[lk_set][0];
    end
    if ((state == lsu_pkg::ST_STORE_REQ) && mem_req_valid) begin
      tag_mem[req_set][wr_way]  <= req_tag;
      data_mem[req_set][wr_way] <= req_wdata;
    end
    if ((state == lsu_pkg::ST_MISS_WAIT) && mem_rvalid) begin
      tag_mem[req_set][lru[req_set]]  <= req_tag; // Refill into the LRU way
      data_mem[req_set][lru[req_set]] <= mem_rdata;
      req_word                        <= mem_rdata;
    end
  end

endmodule

// ==== source/lsu_result.sv ====
module lsu_result (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              done,
  input  lsu_pkg::mem_op_e  done_op,
  input  logic [31:0]       done_word,
  input  logic [1:0]        done_byte_sel,
  input  logic              done_hit,
  output logic              res_valid,
  output logic [31:0]       res_data,
  output logic              res_hit,
  output logic              res_error
);

  logic [7:0]  lane_b;
  logic [15:0] lane_h;
  logic [31:0] data_nxt;
  logic        error_nxt;

  // Little-endian lane pick
  always_comb begin
    case (done_byte_sel)
      2'd0:    lane_b = done_word[7:0];
      2'd1:    lane_b = done_word[15:8];
      2'd2:    lane_b = done_word[23:16];
      default: lane_b = done_word[31:24];
    endcase
  end

  assign lane_h = done_byte_sel[1] ? done_word[31:16] : done_word[15:0];

  always_comb begin
    error_nxt = 1'b0;
    case (done_op)
      lsu_pkg::OP_LB:  data_nxt = {{24{lane_b[7]}}, lane_b};
      lsu_pkg::OP_LBU: data_nxt = {24'd0, lane_b};
      lsu_pkg::OP_LH:  data_nxt = {{16{lane_h[15]}}, lane_h};
      lsu_pkg::OP_LHU: data_nxt = {16'd0, lane_h};
      lsu_pkg::OP_LW:  data_nxt = done_word;
      lsu_pkg::OP_SW:  data_nxt = 32'd0; // Stores return no data
      default: begin
        data_nxt  = 32'd0;
        error_nxt = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) res_valid <= 1'b0;
    else         res_valid <= done; // Single-cycle, no back-pressure
  end

  always_ff @(posedge clk) begin
    if (done) begin
      res_data  <= data_nxt;
      res_hit   <= done_hit;
      res_error <= error_nxt;
    end
  end

endmodule

// ==== source/lsu_top.sv ====
module lsu_top (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  logic        in_is_store,
  input  logic [2:0]  in_funct3,
  input  logic [31:0] in_base,
  input  logic [11:0] in_offset,
  input  logic [31:0] in_store_data,
  output logic        res_valid,
  output logic [31:0] res_data,
  output logic        res_hit,
  output logic        res_error,
  output logic        mem_req_valid,
  output logic        mem_req_write,
  output logic [31:0] mem_req_addr,
  output logic [31:0] mem_req_wdata,
  input  logic        mem_credit,
  input  logic        mem_rvalid,
  input  logic [31:0] mem_rdata
);

  lsu_pkg::mem_op_e dec_op;
  logic [1:0]       dec_size_log2;
  logic             ex_valid;
  lsu_pkg::mem_op_e ex_op;
  logic [31:0]      ex_addr;
  logic [31:0]      ex_wdata;
  logic             cache_take;
  logic             done;
  lsu_pkg::mem_op_e done_op;
  logic [31:0]      done_word;
  logic [1:0]       done_byte_sel;
  logic             done_hit;

  lsu_decode u_decode (.is_store(in_is_store), .funct3(in_funct3), .op(dec_op),
    .size_log2(dec_size_log2));

  lsu_execute u_execute (.clk, .arst_n, .in_valid, .in_ready, .op(dec_op),
    .size_log2(dec_size_log2), .base(in_base), .offset(in_offset),
    .store_data(in_store_data), .cache_take, .ex_valid, .ex_op, .ex_addr, .ex_wdata);

  two_way_cache u_cache (.clk, .arst_n, .ex_valid, .ex_op, .ex_addr, .ex_wdata,
    .cache_take, .done, .done_op, .done_word, .done_byte_sel, .done_hit,
    .mem_req_valid, .mem_req_write, .mem_req_addr, .mem_req_wdata,
    .mem_credit, .mem_rvalid, .mem_rdata);

  lsu_result u_result (.clk, .arst_n, .done, .done_op, .done_word, .done_byte_sel,
    .done_hit, .res_valid, .res_data, .res_hit, .res_error);

endmodule

// ==== verification/lsu_mem_model.sv ====
`include "lsu_settings.svh"

module lsu_mem_model (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req_valid,
  input  logic        req_write,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  output logic        credit,
  output logic        rvalid,
  output logic [31:0] rdata
);

  logic [31:0] mem [256];
  logic [64:0] req_q [$:`LSU_MEM_CREDITS-1]; // {write, addr, wdata}
  logic [64:0] head;
  logic [1:0]  phase;                        // Removal slot every third cycle
  logic        rd_pend;
  logic [7:0]  rd_idx;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'(i) * 32'h0101_0101;       // Fill tied to the word index
    end
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_q.delete();
      phase   <= 2'd0;
      credit  <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      rd_pend <= 1'b0;
      rd_idx  <= '0;
    end else begin
      phase   <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
      credit  <= 1'b0;
      rd_pend <= 1'b0;
      rvalid  <= rd_pend;                    // Answer one cycle after removal
      rdata   <= mem[rd_idx];
      if ((phase == 2'd2) && (req_q.size() != 0)) begin
        head = req_q.pop_front();
        credit <= 1'b1;                      // Slot freed, credit back
        if (head[64]) begin
          mem[head[41:34]] = head[31:0];     // Posted write lands here
        end else begin
          rd_pend <= 1'b1;
          rd_idx  <= head[41:34];
        end
      end
      if (req_valid) begin
        req_q.push_back({req_write, req_addr, req_wdata});
      end
    end
  end

endmodule

// ==== verification/lsu_tb.sv ====
`include "lsu_settings.svh"

module lsu_tb;

  localparam int N_DIRECTED = 44;
  localparam int N_RANDOM   = 200;
  localparam int LIMIT      = 60 * (N_DIRECTED + N_RANDOM) + 100; // Cycles

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  logic        in_ready;
  logic        in_is_store;
  logic [2:0]  in_funct3;
  logic [31:0] in_base;
  logic [11:0] in_offset;
  logic [31:0] in_store_data;
  logic        res_valid;
  logic [31:0] res_data;
  logic        res_hit;
  logic        res_error;
  logic        mem_req_valid;
  logic        mem_req_write;
  logic [31:0] mem_req_addr;
  logic [31:0] mem_req_wdata;
  logic        mem_credit;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;

  logic [31:0] ref_mem [256];                // Expected memory contents
  logic [1:0]  ref_valid [`LSU_NUM_SETS];
  logic [27:0] ref_tag [`LSU_NUM_SETS][2];
  logic        ref_lru [`LSU_NUM_SETS];      // Way to replace next
  logic [33:0] exp_q [$];                    // {data, hit, error} per accepted instr
  logic [64:0] req_exp_q [$];                // {write, addr, wdata} per expected request
  int          exp_reqs = 0;
  int          req_count = 0;
  int          data_errors = 0;
  int          other_errors = 0;
  int          n_checked = 0;
  int          cycles = 0;

  lsu_top UUT (.*);

  lsu_mem_model u_mem (.clk, .arst_n, .req_valid(mem_req_valid), .req_write(mem_req_write),
    .req_addr(mem_req_addr), .req_wdata(mem_req_wdata), .credit(mem_credit),
    .rvalid(mem_rvalid), .rdata(mem_rdata));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Expected result, plus cache and memory bookkeeping
  function automatic void ref_model(input logic st, input logic [2:0] f3,
      input logic [31:0] base, input logic [11:0] off, input logic [31:0] wd,
      output logic [31:0] d, output logic h, output logic e);
    logic [31:0] a;
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] hw;
    logic [1:0]  set;
    logic        hit;
    logic        way;
    a   = base + {{20{off[11]}}, off};
    set = a[3:2];
    hit = 1'b1;
    if (ref_valid[set][1] && (ref_tag[set][1] == a[31:4])) way = 1'b1;
    else if (ref_valid[set][0] && (ref_tag[set][0] == a[31:4])) way = 1'b0;
    else begin
      hit = 1'b0;
      way = ref_lru[set];                    // Victim on a miss
    end
    if (st) e = (f3 != 3'b010) || (a[1:0] != 2'b00); // SW only, word aligned
    else begin
      case (f3)
        3'b000, 3'b100: e = 1'b0;
        3'b001, 3'b101: e = a[0];
        3'b010:         e = (a[1:0] != 2'b00);
        default:        e = 1'b1;            // Reserved load codes
      endcase
    end
    d = 32'd0;
    h = 1'b0;
    if (!e) begin
      h = hit;
      if (st || !hit) begin
        exp_reqs++;                          // Write-through or refill
        req_exp_q.push_back({st, a[31:2], 2'b00, wd});
      end
      ref_valid[set][way] = 1'b1;
      ref_tag[set][way]   = a[31:4];
      ref_lru[set]        = ~way;
      if (st) ref_mem[a[9:2]] = wd;
      else begin
        w  = ref_mem[a[9:2]];
        b  = w[{a[1:0], 3'b000} +: 8];
        hw = w[{a[1], 4'b0000} +: 16];
        case (f3)
          3'b000:  d = {{24{b[7]}}, b};
          3'b100:  d = {24'd0, b};
          3'b001:  d = {{16{hw[15]}}, hw};
          3'b101:  d = {16'd0, hw};
          default: d = w;
        endcase
      end
    end
  endfunction

  // Called at posedge + 10, returns at the posedge + 10 after acceptance
  task automatic send(input logic st, input logic [2:0] f3, input logic [31:0] base,
                      input logic [11:0] off, input logic [31:0] wd);
    logic [31:0] d;
    logic        h;
    logic        e;
    in_valid      = 1'b1;
    in_is_store   = st;
    in_funct3     = f3;
    in_base       = base;
    in_offset     = off;
    in_store_data = wd;
    ref_model(st, f3, base, off, wd, d, h, e);
    exp_q.push_back({d, h, e});
    @(negedge clk);
    while (!in_ready) @(negedge clk);       // Transfer on the next rising edge
    @(posedge clk);
    #10;
  endtask

  task automatic drain();
    in_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    #10;
  endtask

  initial begin
    int          req_snap;
    logic        st;
    logic [2:0]  f3;
    logic [31:0] base;
    logic [11:0] off;
    void'($urandom(27105));
    arst_n        = 1'b0;
    in_valid      = 1'b0;
    in_is_store   = 1'b0;
    in_funct3     = 3'd0;
    in_base       = 32'd0;
    in_offset     = 12'd0;
    in_store_data = 32'd0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 32'(i) * 32'h0101_0101;
    end
    for (int s = 0; s < `LSU_NUM_SETS; s++) begin
      ref_valid[s] = 2'b00;
      ref_lru[s]   = 1'b0;
    end
    repeat (4) @(posedge clk);
    #10 arst_n = 1'b1;
    send(1'b0, 3'b010, 32'h30, 12'h010, 32'd0); // Cold miss
    send(1'b0, 3'b010, 32'h50, 12'hFF0, 32'd0); // Same word, negative offset, hit
    drain();
    send(1'b1, 3'b010, 32'h48, 12'd0, 32'h5A3C_96E1);
    send(1'b0, 3'b010, 32'h48, 12'd0, 32'd0); // Hit on the stored line
    send(1'b0, 3'b010, 32'h58, 12'd0, 32'd0);
    send(1'b0, 3'b010, 32'h68, 12'd0, 32'd0); // Evicts 0x48
    send(1'b0, 3'b010, 32'h48, 12'd0, 32'd0); // Refill sees the written-through word
    drain();
    send(1'b0, 3'b010, 32'h04, 12'd0, 32'd0); // Set 1, three tags
    send(1'b0, 3'b010, 32'h14, 12'd0, 32'd0);
    send(1'b0, 3'b010, 32'h04, 12'd0, 32'd0);
    send(1'b0, 3'b010, 32'h24, 12'd0, 32'd0); // Replaces 0x14
    send(1'b0, 3'b010, 32'h04, 12'd0, 32'd0);
    send(1'b0, 3'b010, 32'h14, 12'd0, 32'd0);
    drain();
    send(1'b1, 3'b010, 32'h26C, 12'd0, 32'h81C3_7F3C); // Mixed sign lanes
    for (int w = 0; w < 2; w++) begin
      for (int l = 0; l < 4; l++) begin
        send(1'b0, 3'b000, 32'h268 + 32'(4 * w), 12'(l), 32'd0);
        send(1'b0, 3'b100, 32'h268 + 32'(4 * w), 12'(l), 32'd0);
      end
      for (int l = 0; l < 2; l++) begin
        send(1'b0, 3'b001, 32'h268 + 32'(4 * w), 12'(2 * l), 32'd0);
        send(1'b0, 3'b101, 32'h268 + 32'(4 * w), 12'(2 * l), 32'd0);
      end
    end
    drain();
    req_snap = req_count;
    send(1'b0, 3'b010, 32'h41, 12'd0, 32'd0); // Misaligned LW
    send(1'b0, 3'b001, 32'h40, 12'd3, 32'd0); // Misaligned LH
    send(1'b1, 3'b000, 32'h40, 12'd0, 32'h1234_5678); // SB
    send(1'b0, 3'b011, 32'h40, 12'd0, 32'd0);
    send(1'b0, 3'b110, 32'h40, 12'd0, 32'd0);
    send(1'b0, 3'b111, 32'h40, 12'd0, 32'd0);
    drain();
    if (req_count != req_snap) begin
      $display("Rejected instructions issued %0d memory requests", req_count - req_snap);
      other_errors++;
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      st   = (($urandom % 4) == 0);
      f3   = st ? ((($urandom % 4) == 0) ? 3'b000 : 3'b010) : 3'($urandom % 8);
      base = 32'(($urandom % 48) * 4 + 16);
      off  = 12'($urandom % 8) * 12'd4 - 12'd12;  // Word steps, some negative
      if (($urandom % 4) == 0) off = off + 12'($urandom % 4); // Sub-word lanes
      send(st, f3, base, off, $urandom);
    end
    drain();
    if (req_count != exp_reqs) begin
      $display("Memory saw %0d requests where %0d were expected", req_count, exp_reqs);
      other_errors++;
    end
    $display("Results checked %0d, data errors %0d, other errors %0d",
             n_checked, data_errors, other_errors);
    if ((data_errors == 0) && (other_errors == 0)) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Compare results in acceptance order, sampled mid-cycle
  always @(negedge clk) begin
    logic [33:0] want;
    if (arst_n && res_valid) begin
      if (exp_q.size() == 0) begin
        $display("A result appeared with no accepted instruction waiting for it");
        data_errors++;
      end else begin
        want = exp_q.pop_front();
        n_checked++;
        if (res_data !== want[33:2]) begin
          $display("[ERROR] res_data got %h expected %h", res_data, want[33:2]);
          data_errors++;
        end
        if (res_hit !== want[1]) begin
          $display("[ERROR] res_hit got %h expected %h", res_hit, want[1]);
          data_errors++;
        end
        if (res_error !== want[0]) begin
          $display("[ERROR] res_error got %h expected %h", res_error, want[0]);
          data_errors++;
        end
      end
    end
  end

  // Memory requests in issue order, one cycle each
  always @(negedge clk) begin
    logic [64:0] req_want;
    if (arst_n && mem_req_valid) begin
      req_count++;
      if (req_exp_q.size() == 0) begin
        $display("A memory request appeared that no instruction needs");
        other_errors++;
      end else begin
        req_want = req_exp_q.pop_front();
        if (mem_req_write !== req_want[64]) begin
          $display("[ERROR] mem_req_write got %h expected %h", mem_req_write, req_want[64]);
          data_errors++;
        end
        if (mem_req_addr !== req_want[63:32]) begin
          $display("[ERROR] mem_req_addr got %h expected %h", mem_req_addr,
                   req_want[63:32]);
          data_errors++;
        end
        if (req_want[64] && (mem_req_wdata !== req_want[31:0])) begin
          $display("[ERROR] mem_req_wdata got %h expected %h", mem_req_wdata,
                   req_want[31:0]);
          data_errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, no result arrived for %0d instructions",
               cycles, exp_q.size());
      $display("STATUS: FAIL");
      $finish;
    end
  end

endmodule

// ==== lsu_top.f ====
+incdir+source
source/lsu_pkg.sv
source/lsu_decode.sv
source/lsu_execute.sv
source/two_way_cache.sv
source/lsu_result.sv
source/lsu_top.sv
verification/lsu_mem_model.sv
verification/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= lsu_top.f
RTL_TOP   ?= lsu_top
TB_TOP    ?= lsu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
